// ==== hdl/ctl_consts.svh ====
`ifndef CTL_CONSTS_SVH
`define CTL_CONSTS_SVH

////////////////////////////////////////////////////////////
// field widths
////////////////////////////////////////////////////////////
`define CTL_OPCODE_W        6
`define CTL_MEM_OP_W        5
`define CTL_WB_OP_W         2
`define CTL_ALU_OP_W        3
`define CTL_RETIRE_W        16

////////////////////////////////////////////////////////////
// opcode classes
////////////////////////////////////////////////////////////
// below this, alu class; from here up to the illegal base, system class
`define CTL_ALU_CLASS_END   32
`define CTL_ILLEGAL_BASE    46

// memory sub-operation codes
`define CTL_MEM_NONE        0
`define CTL_MEM_LOAD        1
`define CTL_MEM_STORE       2
`define CTL_MEM_IO_OUT      3

// writeback sub-operation codes
`define CTL_WB_NONE         0
`define CTL_WB_ALU          1
`define CTL_WB_MEM          2
`define CTL_WB_LINK         3

`endif

// ==== hdl/ctl_pkg.sv ====
`include "ctl_consts.svh"

package ctl_pkg;

    ////////////////////////////////////////////////////////////
    // vector types
    ////////////////////////////////////////////////////////////
    typedef logic [`CTL_OPCODE_W-1:0] opcode_t;
    typedef logic [`CTL_MEM_OP_W-1:0] mem_op_t;
    typedef logic [`CTL_WB_OP_W-1:0]  wb_op_t;
    typedef logic [`CTL_ALU_OP_W-1:0] alu_op_t;
    typedef logic [`CTL_RETIRE_W-1:0] retire_cnt_t;

    ////////////////////////////////////////////////////////////
    // per-stage state machines
    ////////////////////////////////////////////////////////////
    typedef enum logic [2:0]
    {
        FD_IDLE,
        FD_IRQ_SAVE,
        FD_IRQ_VECTOR,
        FD_FETCH,
        FD_DECODE,
        FD_EXT_FETCH,
        FD_ISSUE
    } fetch_state_e;

    typedef enum logic [2:0]
    {
        MS_IDLE,
        MS_DMEM_WAIT,
        MS_IO_RAISE,
        MS_IO_RELEASE,
        MS_HANDOFF
    } mem_state_e;

    typedef enum logic
    {
        WB_EMPTY,
        WB_WRITE
    } wb_state_e;

    // source of the register-file write data
    typedef enum logic [1:0]
    {
        SRC_ALU,
        SRC_MEM,
        SRC_LINK
    } wb_src_e;

    ////////////////////////////////////////////////////////////
    // hand-off structs
    ////////////////////////////////////////////////////////////
    typedef struct packed
    {
        opcode_t opcode;
        mem_op_t mem_op;
        wb_op_t  wb_op;
    } instr_t;

    typedef struct packed
    {
        logic    valid;
        alu_op_t alu_op;
        logic    use_imm;
    } alu_cmd_t;

    typedef struct packed
    {
        mem_op_t mem_op;
        wb_op_t  wb_op;
    } mem_item_t;

    typedef struct packed
    {
        logic    wb_en;
        wb_src_e wb_src;
    } wb_item_t;

    typedef struct packed
    {
        logic valid;
        logic write;
    } dmem_cmd_t;

    typedef struct packed
    {
        logic    valid;
        wb_src_e src;
    } reg_write_t;

endpackage

// ==== hdl/fetch_decode.sv ====
`timescale 1ns/1ps
`include "ctl_consts.svh"

module fetch_decode
(
    input  logic               clk,
    input  logic               rst_n,
    input  logic               irq_pending,
    input  logic               imem_ack,
    input  ctl_pkg::instr_t    instr,
    input  logic               mem_ready,
    output logic               imem_req,
    output logic               irq_ack,
    output ctl_pkg::alu_cmd_t  alu_cmd,
    output logic               illegal,
    output ctl_pkg::mem_item_t mem_item,
    output logic               mem_valid
);

    ctl_pkg::fetch_state_e state;
    ctl_pkg::fetch_state_e state_next;

    // latched word and its registered decode
    ctl_pkg::instr_t    instr_q;
    ctl_pkg::alu_op_t   alu_op_q;
    logic               use_imm_q;
    logic               is_alu_q;
    logic               is_illegal_q;
    ctl_pkg::mem_item_t item_q;

    // set after the first ISSUE cycle
    logic issued;

    logic op_alu;
    logic op_illegal;
    logic first_issue;

    ////////////////////////////////////////////////////////////
    // opcode class of the latched word
    ////////////////////////////////////////////////////////////
    assign op_alu     = instr_q.opcode < ctl_pkg::opcode_t'(`CTL_ALU_CLASS_END);
    assign op_illegal = instr_q.opcode >= ctl_pkg::opcode_t'(`CTL_ILLEGAL_BASE);

    ////////////////////////////////////////////////////////////
    // state machine
    ////////////////////////////////////////////////////////////
    always_comb
    begin
        state_next = state;
        case (state)
            ctl_pkg::FD_IDLE:
            begin
                if (irq_pending)
                    state_next = ctl_pkg::FD_IRQ_SAVE;
                else
                    state_next = ctl_pkg::FD_FETCH;
            end
            ctl_pkg::FD_IRQ_SAVE:   state_next = ctl_pkg::FD_IRQ_VECTOR;
            ctl_pkg::FD_IRQ_VECTOR: state_next = ctl_pkg::FD_FETCH;
            ctl_pkg::FD_FETCH:
            begin
                if (imem_ack)
                    state_next = ctl_pkg::FD_DECODE;
            end
            ctl_pkg::FD_DECODE:
            begin
                // alu opcodes with bit 0 set carry an extension word
                if (op_alu && instr_q.opcode[0])
                    state_next = ctl_pkg::FD_EXT_FETCH;
                else
                    state_next = ctl_pkg::FD_ISSUE;
            end
            ctl_pkg::FD_EXT_FETCH:
            begin
                if (imem_ack)
                    state_next = ctl_pkg::FD_ISSUE;
            end
            ctl_pkg::FD_ISSUE:
            begin
                if (mem_ready)
                    state_next = ctl_pkg::FD_IDLE;
            end
            default: state_next = ctl_pkg::FD_IDLE;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            state  <= ctl_pkg::FD_IDLE;
            issued <= 1'b0;
        end
        else
        begin
            state  <= state_next;
            issued <= (state == ctl_pkg::FD_ISSUE) && !mem_ready;
        end
    end

    ////////////////////////////////////////////////////////////
    // instruction latch and decode
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk)
    begin
        if (state == ctl_pkg::FD_FETCH && imem_ack)
            instr_q <= instr;
        if (state == ctl_pkg::FD_DECODE)
        begin
            alu_op_q     <= instr_q.opcode[4:2];
            use_imm_q    <= instr_q.opcode[1];
            is_alu_q     <= op_alu;
            is_illegal_q <= op_illegal;
            // system and illegal opcodes go down as no-ops
            if (op_alu)
            begin
                item_q.mem_op <= instr_q.mem_op;
                item_q.wb_op  <= instr_q.wb_op;
            end
            else
            begin
                item_q.mem_op <= ctl_pkg::mem_op_t'(`CTL_MEM_NONE);
                item_q.wb_op  <= ctl_pkg::wb_op_t'(`CTL_WB_NONE);
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // outputs
    ////////////////////////////////////////////////////////////
    assign first_issue = (state == ctl_pkg::FD_ISSUE) && !issued;

    assign imem_req = (state == ctl_pkg::FD_FETCH) || (state == ctl_pkg::FD_EXT_FETCH);
    assign irq_ack  = state == ctl_pkg::FD_IRQ_VECTOR;

    assign alu_cmd.valid   = first_issue && is_alu_q;
    assign alu_cmd.alu_op  = alu_op_q;
    assign alu_cmd.use_imm = use_imm_q;
    assign illegal         = first_issue && is_illegal_q;

    assign mem_valid = state == ctl_pkg::FD_ISSUE;
    assign mem_item  = item_q;

endmodule

// ==== hdl/mem_sequencer.sv ====
`timescale 1ns/1ps
`include "ctl_consts.svh"

module mem_sequencer
(
    input  logic               clk,
    input  logic               rst_n,
    input  ctl_pkg::mem_item_t mem_item,
    input  logic               mem_valid,
    input  logic               dmem_ack,
    input  logic               io_ack,
    input  logic               wb_ready,
    output logic               mem_ready,
    output ctl_pkg::dmem_cmd_t dmem_cmd,
    output logic               io_req,
    output ctl_pkg::wb_item_t  wb_item,
    output logic               wb_valid
);

    ctl_pkg::mem_state_e state;
    ctl_pkg::mem_state_e state_next;

    // item held while its memory action runs
    ctl_pkg::mem_item_t item_q;

    logic accept;

    assign accept = (state == ctl_pkg::MS_IDLE) && mem_valid;

    ////////////////////////////////////////////////////////////
    // state machine
    ////////////////////////////////////////////////////////////
    always_comb
    begin
        state_next = state;
        case (state)
            ctl_pkg::MS_IDLE:
            begin
                if (mem_valid)
                begin
                    case (mem_item.mem_op)
                        ctl_pkg::mem_op_t'(`CTL_MEM_LOAD),
                        ctl_pkg::mem_op_t'(`CTL_MEM_STORE):
                            state_next = ctl_pkg::MS_DMEM_WAIT;
                        ctl_pkg::mem_op_t'(`CTL_MEM_IO_OUT):
                            state_next = ctl_pkg::MS_IO_RAISE;
                        // no memory action, straight to the hand-off
                        default:
                            state_next = ctl_pkg::MS_HANDOFF;
                    endcase
                end
            end
            ctl_pkg::MS_DMEM_WAIT:
            begin
                if (dmem_ack)
                    state_next = ctl_pkg::MS_HANDOFF;
            end
            ctl_pkg::MS_IO_RAISE:
            begin
                if (io_ack)
                    state_next = ctl_pkg::MS_IO_RELEASE;
            end
            ctl_pkg::MS_IO_RELEASE:
            begin
                // io_ack must be back low before the next rise
                if (!io_ack)
                    state_next = ctl_pkg::MS_HANDOFF;
            end
            ctl_pkg::MS_HANDOFF:
            begin
                if (wb_ready)
                    state_next = ctl_pkg::MS_IDLE;
            end
            default: state_next = ctl_pkg::MS_IDLE;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (!rst_n)
            state <= ctl_pkg::MS_IDLE;
        else
            state <= state_next;
    end

    always_ff @(posedge clk)
    begin
        if (accept)
            item_q <= mem_item;
    end

    ////////////////////////////////////////////////////////////
    // handshake outputs
    ////////////////////////////////////////////////////////////
    assign mem_ready = state == ctl_pkg::MS_IDLE;

    assign dmem_cmd.valid = state == ctl_pkg::MS_DMEM_WAIT;
    assign dmem_cmd.write = item_q.mem_op == ctl_pkg::mem_op_t'(`CTL_MEM_STORE);

    assign io_req   = state == ctl_pkg::MS_IO_RAISE;
    assign wb_valid = state == ctl_pkg::MS_HANDOFF;

    // wb_op to enable and source
    always_comb
    begin
        wb_item.wb_en  = 1'b1;
        wb_item.wb_src = ctl_pkg::SRC_ALU;
        case (item_q.wb_op)
            ctl_pkg::wb_op_t'(`CTL_WB_NONE): wb_item.wb_en  = 1'b0;
            ctl_pkg::wb_op_t'(`CTL_WB_ALU):  wb_item.wb_src = ctl_pkg::SRC_ALU;
            ctl_pkg::wb_op_t'(`CTL_WB_MEM):  wb_item.wb_src = ctl_pkg::SRC_MEM;
            ctl_pkg::wb_op_t'(`CTL_WB_LINK): wb_item.wb_src = ctl_pkg::SRC_LINK;
            default:                         wb_item.wb_en  = 1'b0;
        endcase
    end

endmodule

// ==== hdl/writeback_sequencer.sv ====
`timescale 1ns/1ps

module writeback_sequencer
(
    input  logic                 clk,
    input  logic                 rst_n,
    input  ctl_pkg::wb_item_t    wb_item,
    input  logic                 wb_valid,
    input  logic                 rf_ready,
    output logic                 wb_ready,
    output ctl_pkg::reg_write_t  reg_write,
    output ctl_pkg::retire_cnt_t retire_count
);

    ctl_pkg::wb_state_e state;

    // source of the pending write
    ctl_pkg::wb_src_e src_q;

    logic accept;

    assign accept = (state == ctl_pkg::WB_EMPTY) && wb_valid;

    ////////////////////////////////////////////////////////////
    // buffer state and retire counter
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            state        <= ctl_pkg::WB_EMPTY;
            retire_count <= '0;
        end
        else
        begin
            if (accept)
                retire_count <= retire_count + 1'b1;
            case (state)
                ctl_pkg::WB_EMPTY:
                begin
                    // items without a write retire here
                    if (accept && wb_item.wb_en)
                        state <= ctl_pkg::WB_WRITE;
                end
                ctl_pkg::WB_WRITE:
                begin
                    if (rf_ready)
                        state <= ctl_pkg::WB_EMPTY;
                end
                default: state <= ctl_pkg::WB_EMPTY;
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (accept)
            src_q <= wb_item.wb_src;
    end

    assign wb_ready        = state == ctl_pkg::WB_EMPTY;
    assign reg_write.valid = state == ctl_pkg::WB_WRITE;
    assign reg_write.src   = src_q;

endmodule

// ==== hdl/pipe_ctl_top.sv ====
`timescale 1ns/1ps

module pipe_ctl_top
(
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 irq_pending,
    input  logic                 imem_ack,
    input  ctl_pkg::instr_t      instr,
    input  logic                 dmem_ack,
    input  logic                 io_ack,
    input  logic                 rf_ready,
    output logic                 imem_req,
    output logic                 irq_ack,
    output ctl_pkg::alu_cmd_t    alu_cmd,
    output logic                 illegal,
    output ctl_pkg::dmem_cmd_t   dmem_cmd,
    output logic                 io_req,
    output ctl_pkg::reg_write_t  reg_write,
    output ctl_pkg::retire_cnt_t retire_count
);

    ////////////////////////////////////////////////////////////
    // stage hand-offs
    ////////////////////////////////////////////////////////////
    ctl_pkg::mem_item_t mem_item;
    logic               mem_valid;
    logic               mem_ready;
    ctl_pkg::wb_item_t  wb_item;
    logic               wb_valid;
    logic               wb_ready;

    // fetch, decode and issue
    fetch_decode fetch_decode_i
    (
        .clk         (clk),
        .rst_n       (rst_n),
        .irq_pending (irq_pending),
        .imem_ack    (imem_ack),
        .instr       (instr),
        .mem_ready   (mem_ready),
        .imem_req    (imem_req),
        .irq_ack     (irq_ack),
        .alu_cmd     (alu_cmd),
        .illegal     (illegal),
        .mem_item    (mem_item),
        .mem_valid   (mem_valid)
    );

    // data memory and io output
    mem_sequencer mem_sequencer_i
    (
        .clk       (clk),
        .rst_n     (rst_n),
        .mem_item  (mem_item),
        .mem_valid (mem_valid),
        .dmem_ack  (dmem_ack),
        .io_ack    (io_ack),
        .wb_ready  (wb_ready),
        .mem_ready (mem_ready),
        .dmem_cmd  (dmem_cmd),
        .io_req    (io_req),
        .wb_item   (wb_item),
        .wb_valid  (wb_valid)
    );

    // register writes and retire count
    writeback_sequencer writeback_sequencer_i
    (
        .clk          (clk),
        .rst_n        (rst_n),
        .wb_item      (wb_item),
        .wb_valid     (wb_valid),
        .rf_ready     (rf_ready),
        .wb_ready     (wb_ready),
        .reg_write    (reg_write),
        .retire_count (retire_count)
    );

endmodule

// ==== bench/pipe_ctl_tb.sv ====
`timescale 1ns/1ps
`include "ctl_consts.svh"

module pipe_ctl_tb;

    localparam int WAIT_LIMIT = 400;

    logic                 clk;
    logic                 rst_n;
    logic                 irq_pending;
    logic                 imem_ack;
    ctl_pkg::instr_t      instr;
    logic                 dmem_ack;
    logic                 io_ack;
    logic                 rf_ready;
    logic                 imem_req;
    logic                 irq_ack;
    ctl_pkg::alu_cmd_t    alu_cmd;
    logic                 illegal;
    ctl_pkg::dmem_cmd_t   dmem_cmd;
    logic                 io_req;
    ctl_pkg::reg_write_t  reg_write;
    ctl_pkg::retire_cnt_t retire_count;

    integer seed = 32'h77a8_08fa;

    // program and expected events, in file order
    int               irq_list[$];
    ctl_pkg::instr_t  word_list[$];
    logic [5:0]       decode_exp[$];
    logic             dmem_exp[$];
    ctl_pkg::wb_src_e wb_exp[$];
    int ext_words = 0;
    int irq_lines = 0;
    int io_lines  = 0;

    // event counters kept by the monitor
    int   imem_xfers = 0;
    int   irq_acks   = 0;
    int   io_cycles  = 0;
    logic io_req_d   = 1'b0;

    pipe_ctl_top dut_i
    (
        .clk          (clk),
        .rst_n        (rst_n),
        .irq_pending  (irq_pending),
        .imem_ack     (imem_ack),
        .instr        (instr),
        .dmem_ack     (dmem_ack),
        .io_ack       (io_ack),
        .rf_ready     (rf_ready),
        .imem_req     (imem_req),
        .irq_ack      (irq_ack),
        .alu_cmd      (alu_cmd),
        .illegal      (illegal),
        .dmem_cmd     (dmem_cmd),
        .io_req       (io_req),
        .reg_write    (reg_write),
        .retire_count (retire_count)
    );

    initial
    begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    ////////////////////////////////////////////////////////////
    // error reporting
    ////////////////////////////////////////////////////////////
    task automatic stop_with_failure();
        $display("Test failed");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] exp,
                                   input logic [31:0] act);
        $display("[FAIL] %s: expected %0h, actual %0h", name, exp, act);
        stop_with_failure();
    endtask

    task automatic report_error(input string what);
        $display("%s", what);
        stop_with_failure();
    endtask

    ////////////////////////////////////////////////////////////
    // stimulus file
    ////////////////////////////////////////////////////////////
    task automatic load_program();
        int    fd;
        int    n;
        string line;
        int    irq, op, mop, wop, av, aop, imm, ill, dm, io, wb;
        fd = $fopen("bench/pipe_ctl_stimulus.txt", "r");
        if (fd == 0)
            report_error("cannot open bench/pipe_ctl_stimulus.txt");
        while (!$feof(fd))
        begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() < 2 || line.getc(0) == "#")
                continue;
            n = $sscanf(line, "%d %d %d %d %d %d %d %d %d %d %d",
                        irq, op, mop, wop, av, aop, imm, ill, dm, io, wb);
            if (n != 11)
                report_error({"malformed stimulus line: ", line});
            irq_list.push_back(irq);
            word_list.push_back({op[5:0], mop[4:0], wop[1:0]});
            if (av != 0 || ill != 0)
                decode_exp.push_back({av[0], aop[2:0], imm[0], ill[0]});
            // alu opcodes with bit 0 set fetch one extension word
            if (op < `CTL_ALU_CLASS_END && op[0])
                ext_words++;
            if (dm != 0)
                dmem_exp.push_back(dm == 2);
            if (wb != 0)
                wb_exp.push_back(ctl_pkg::wb_src_e'(wb - 1));
            irq_lines += (irq != 0);
            io_lines  += (io != 0);
        end
        $fclose(fd);
    endtask

    task automatic check_reset_state();
        logic [8:0] ctl_bits;
        ctl_bits = {imem_req, irq_ack, alu_cmd.valid, illegal, dut_i.mem_valid,
                    dmem_cmd.valid, io_req, dut_i.wb_valid, reg_write.valid};
        assert (ctl_bits == '0)
            else report_mismatch("control outputs in reset", 0, ctl_bits);
        assert (retire_count == '0)
            else report_mismatch("retire_count in reset", 0, retire_count);
    endtask

    ////////////////////////////////////////////////////////////
    // instruction side and interrupt
    ////////////////////////////////////////////////////////////
    task automatic answer_fetch(input ctl_pkg::instr_t word);
        int n;
        n = 0;
        do
        begin
            @(posedge clk);
            n++;
        end
        while (!imem_req && n < WAIT_LIMIT);
        if (!imem_req)
            report_error("imem_req did not rise for an instruction fetch");
        repeat ($random(seed) & 3)
            @(posedge clk);
        imem_ack <= 1'b1;
        instr    <= word;
        @(posedge clk);
        imem_ack <= 1'b0;
    endtask

    task automatic wait_irq_ack();
        int n;
        n = 0;
        do
        begin
            @(posedge clk);
            n++;
        end
        while (!irq_ack && n < WAIT_LIMIT);
        if (!irq_ack)
            report_error("irq_ack did not pulse for a pending interrupt");
        irq_pending <= 1'b0;
    endtask

    initial
    begin
        int   irq_due;
        int   n;
        logic ext_due;
        rst_n       = 1'b0;
        irq_pending = 1'b0;
        imem_ack    = 1'b0;
        instr       = '0;
        dmem_ack    = 1'b0;
        io_ack      = 1'b0;
        rf_ready    = 1'b0;
        irq_due     = 0;
        load_program();
        repeat (4)
            @(posedge clk);
        check_reset_state();
        rst_n <= 1'b1;
        for (int i = 0; i < word_list.size(); i++)
        begin
            irq_pending <= (irq_list[i] != 0);
            if (irq_list[i] != 0)
            begin
                irq_due++;
                wait_irq_ack();
            end
            answer_fetch(word_list[i]);
            assert (irq_acks == irq_due)
                else report_mismatch("irq_ack pulses before fetch", irq_due, irq_acks);
            ext_due = (word_list[i].opcode < `CTL_ALU_CLASS_END) && word_list[i].opcode[0];
            // one decode cycle, then the extension request shows up or not
            repeat (2)
                @(posedge clk);
            assert (imem_req == ext_due)
                else report_mismatch("extension fetch request", ext_due, imem_req);
            if (ext_due)
                answer_fetch(ctl_pkg::instr_t'($random(seed)));
        end
        // drain the last instructions
        n = 0;
        while ((retire_count != word_list.size() || wb_exp.size() != 0) && n < WAIT_LIMIT)
        begin
            @(posedge clk);
            n++;
        end
        if (retire_count != word_list.size() || wb_exp.size() != 0)
            report_error("pipeline did not retire every instruction in time");
        assert (imem_xfers == word_list.size() + ext_words)
            else report_mismatch("imem transfers", word_list.size() + ext_words, imem_xfers);
        assert (irq_acks == irq_lines)
            else report_mismatch("irq_ack pulses", irq_lines, irq_acks);
        assert (io_cycles == io_lines)
            else report_mismatch("io handshakes", io_lines, io_cycles);
        assert (dmem_exp.size() == 0)
            else report_mismatch("missing dmem commands", 0, dmem_exp.size());
        assert (decode_exp.size() == 0)
            else report_mismatch("missing decode pulses", 0, decode_exp.size());
        $display("Test passed");
        $finish;
    end

    ////////////////////////////////////////////////////////////
    // data memory, io and register-file responders
    ////////////////////////////////////////////////////////////
    initial
    begin
        forever
        begin
            @(posedge clk);
            if (rst_n && dmem_cmd.valid)
            begin
                if (dmem_exp.size() == 0)
                    report_error("data-memory command appeared with none expected");
                assert (dmem_cmd.write == dmem_exp[0])
                    else report_mismatch("dmem write flag", dmem_exp[0], dmem_cmd.write);
                void'(dmem_exp.pop_front());
                repeat ($random(seed) & 3)
                    @(posedge clk);
                dmem_ack <= 1'b1;
                @(posedge clk);
                dmem_ack <= 1'b0;
            end
        end
    end

    initial
    begin : io_responder
        int n;
        forever
        begin
            @(posedge clk);
            if (rst_n && io_req)
            begin
                repeat ($random(seed) & 3)
                    @(posedge clk);
                io_ack <= 1'b1;
                n = 0;
                do
                begin
                    @(posedge clk);
                    n++;
                end
                while (io_req && n < WAIT_LIMIT);
                if (io_req)
                    report_error("io_req did not drop after io_ack");
                repeat ($random(seed) & 3)
                    @(posedge clk);
                io_ack <= 1'b0;
            end
        end
    end

    // register file stalls about one cycle in four
    initial
    begin
        forever
        begin
            @(posedge clk);
            rf_ready <= ($random(seed) & 3) != 0;
        end
    end

    ////////////////////////////////////////////////////////////
    // monitor
    ////////////////////////////////////////////////////////////
    task automatic check_decode();
        logic [5:0] seen;
        seen = {alu_cmd.valid, alu_cmd.valid ? alu_cmd.alu_op : 3'b0,
                alu_cmd.valid ? alu_cmd.use_imm : 1'b0, illegal};
        if (decode_exp.size() == 0)
            report_error("ALU command or illegal pulse appeared with none expected");
        assert (seen == decode_exp[0])
            else report_mismatch("alu_valid/alu_op/use_imm/illegal", decode_exp[0], seen);
        void'(decode_exp.pop_front());
    endtask

    task automatic check_reg_write();
        if (wb_exp.size() == 0)
            report_error("register write appeared with none expected");
        assert (reg_write.src == wb_exp[0])
            else report_mismatch("reg_write src", wb_exp[0], reg_write.src);
        void'(wb_exp.pop_front());
    endtask

    always @(posedge clk)
    begin
        if (rst_n)
        begin
            if (imem_req && imem_ack)
                imem_xfers <= imem_xfers + 1;
            if (irq_ack)
                irq_acks <= irq_acks + 1;
            if (alu_cmd.valid || illegal)
                check_decode();
            if (reg_write.valid && rf_ready)
                check_reg_write();
            // a new four-phase cycle starts only with io_ack low
            if (io_req && !io_req_d)
            begin
                assert (!io_ack)
                    else report_error("io_req rose while io_ack was still high");
                io_cycles <= io_cycles + 1;
            end
            io_req_d <= io_req;
        end
    end

endmodule

// ==== bench/pipe_ctl_stimulus.txt ====
# irq opcode mem_op wb_op | alu_valid alu_op use_imm illegal | dmem io wb
# dmem 0 none 1 read 2 write, wb 0 none 1 alu 2 mem 3 link (decimal)
1 4 0 1 1 1 0 0 0 0 1
0 11 1 2 1 2 1 0 1 0 2
0 18 2 0 1 4 1 0 2 0 0
0 31 3 3 1 7 1 0 0 1 3
1 33 1 1 0 0 0 0 0 0 0
0 46 2 2 0 0 0 1 0 0 0
0 0 4 1 1 0 0 0 0 0 1
0 29 3 0 1 7 0 0 0 1 0
1 63 3 3 0 0 0 1 0 0 0
0 45 2 3 0 0 0 0 0 0 0
0 22 1 2 1 5 1 0 1 0 2
0 9 31 3 1 2 0 0 0 0 3
1 2 2 1 1 0 1 0 2 0 1
0 32 0 2 0 0 0 0 0 0 0

// ==== list.f ====
+incdir+hdl
hdl/ctl_pkg.sv
hdl/fetch_decode.sv
hdl/mem_sequencer.sv
hdl/writeback_sequencer.sv
hdl/pipe_ctl_top.sv
bench/pipe_ctl_tb.sv
